// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_queue
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Result: FAILED
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/load_queue.sv
`timescale 1ns/1ps
`include "lq_defines.svh"

module load_queue (
    input  logic               clk,
    input  logic               rst,
    input  lq_pkg::dis_req_t   dis,
    input  lq_pkg::ld_issue_t  ld,
    input  lq_pkg::refill_t    refill,
    input  lq_pkg::st_check_t  st,
    input  lq_pkg::redirect_t  redir,
    input  logic [1:0]         commit_num,
    input  logic               wb_ready,
    output lq_pkg::lq_idx_t    dis_lq_idx,
    output logic               lq_full,
    output lq_pkg::wb_t        wb,
    output lq_pkg::violation_t violation
);
    import lq_pkg::*;

    lq_idx_t                                       head;
    logic                                          alloc;
    logic                                          flush;
    logic [`LQ_SIZE-1:0]                           keep_mask;
    logic [`LQ_SIZE-1:0]                           addr_valid_vec;
    logic [`LQ_SIZE-1:0][`PADDR_W-`OFFSET_W-1:0]  word_addr;
    logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0]         byte_mask;
    logic [`LQ_IDX_W-1:0]                          rd_idx;
    rob_idx_t                                      rd_rob;

    lq_alloc u_alloc (
        .clk        (clk),
        .rst        (rst),
        .dis        (dis),
        .commit_num (commit_num),
        .redir      (redir),
        .tail       (dis_lq_idx),  // Tail doubles as the dispatch index
        .head       (head),
        .lq_full    (lq_full),
        .alloc      (alloc),
        .flush      (flush),
        .keep_mask  (keep_mask)
    );

    lq_entries u_entries (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .alloc_idx      (dis_lq_idx),
        .head           (head),
        .commit_num     (commit_num),
        .flush          (flush),
        .keep_mask      (keep_mask),
        .ld             (ld),
        .refill         (refill),
        .wb_ready       (wb_ready),
        .rd_idx         (rd_idx),
        .wb             (wb),
        .addr_valid_vec (addr_valid_vec),
        .word_addr      (word_addr),
        .byte_mask      (byte_mask),
        .rd_rob         (rd_rob)
    );

    lq_violation u_violation (
        .clk            (clk),
        .rst            (rst),
        .st             (st),
        .head           (head),
        .tail           (dis_lq_idx),
        .addr_valid_vec (addr_valid_vec),
        .word_addr      (word_addr),
        .byte_mask      (byte_mask),
        .rd_rob         (rd_rob),
        .rd_idx         (rd_idx),
        .violation      (violation)
    );

endmodule

// File: hdl/lq_alloc.sv
`timescale 1ns/1ps
`include "lq_defines.svh"

module lq_alloc (
    input  logic                clk,
    input  logic                rst,
    input  lq_pkg::dis_req_t    dis,
    input  logic [1:0]          commit_num,
    input  lq_pkg::redirect_t   redir,
    output lq_pkg::lq_idx_t     tail,
    output lq_pkg::lq_idx_t     head,
    output logic                lq_full,
    output logic                alloc,
    output logic                flush,
    output logic [`LQ_SIZE-1:0] keep_mask
);
    import lq_pkg::*;

    rob_idx_t              rob_tab [`LQ_SIZE];
    redirect_t             redir_q;
    lq_idx_t               head_n;
    lq_idx_t               tail_n;
    lq_idx_t               walk_tail;
    logic [`LQ_IDX_W:0]    occ;
    logic [`LQ_IDX_W:0]    keep_cnt;
    logic [`LQ_SIZE-1:0]   younger;

    // True when a comes after b in program order
    function automatic logic rob_after(rob_idx_t a, rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx > b.idx;
        end
        return a.idx < b.idx;
    endfunction

    assign lq_full = (tail.idx == head.idx) && (tail.dir != head.dir);
    assign alloc   = dis.en && !lq_full && !redir_q.en;  // Tail is being rolled back
    assign flush   = redir_q.en;

    // Direction bit is the carry out of the index
    assign head_n = head + {{(`LQ_IDX_W-1){1'b0}}, commit_num};
    assign tail_n = tail + {{`LQ_IDX_W{1'b0}}, alloc};
    assign occ    = tail - head;

    always_ff @(posedge clk) begin
        if (alloc) begin
            rob_tab[tail.idx] <= dis.rob_idx;
        end
    end

    always_comb begin
        for (int i = 0; i < `LQ_SIZE; i++) begin
            younger[i] = rob_after(rob_tab[i], redir_q.rob_idx);
        end
    end

    // Oldest dropped entry, walking from head
    always_comb begin
        logic [`LQ_IDX_W-1:0] pos;
        walk_tail = head_n;
        for (int k = `LQ_SIZE-1; k >= 0; k--) begin
            pos = head.idx + (`LQ_IDX_W)'(k);
            if (k < occ && younger[pos]) begin
                walk_tail = head + (`LQ_IDX_W+1)'(k);
            end
        end
    end

    assign keep_cnt = walk_tail - head_n;

    // Survivors lie between the next head and the new tail
    always_comb begin
        logic [`LQ_IDX_W-1:0] off;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            off = (`LQ_IDX_W)'(i) - head_n.idx;
            keep_mask[i] = {1'b0, off} < keep_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            redir_q <= '0;
        end else begin
            redir_q <= redir;
            head    <= head_n;
            tail    <= redir_q.en ? walk_tail : tail_n;
        end
    end

endmodule

// File: hdl/lq_defines.svh
`ifndef LQ_DEFINES_SVH
`define LQ_DEFINES_SVH

// Queue geometry
`define LQ_SIZE     16
`define LQ_IDX_W    4

// Backend index widths, direction bit not included
`define ROB_IDX_W   6
`define PREG_W      6

// Memory side
`define PADDR_W     32
`define DATA_W      64
`define DATA_BYTES  8
`define OFFSET_W    3

`define COMMIT_W    2   // Loads retired per cycle

`endif

// File: hdl/lq_entries.sv
`timescale 1ns/1ps
`include "lq_defines.svh"

module lq_entries (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           alloc,
    input  lq_pkg::lq_idx_t                                alloc_idx,
    input  lq_pkg::lq_idx_t                                head,
    input  logic [1:0]                                     commit_num,
    input  logic                                           flush,
    input  logic [`LQ_SIZE-1:0]                            keep_mask,
    input  lq_pkg::ld_issue_t                              ld,
    input  lq_pkg::refill_t                                refill,
    input  logic                                           wb_ready,
    input  logic [`LQ_IDX_W-1:0]                           rd_idx,
    output lq_pkg::wb_t                                    wb,
    output logic [`LQ_SIZE-1:0]                            addr_valid_vec,
    output logic [`LQ_SIZE-1:0][`PADDR_W-`OFFSET_W-1:0]   word_addr,
    output logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0]          byte_mask,
    output lq_pkg::rob_idx_t                               rd_rob
);
    import lq_pkg::*;

    typedef struct packed {
        logic                   uext;
        ld_size_e               size;
        logic [`OFFSET_W-1:0]   offset;
        logic [`DATA_BYTES-1:0] rmask;
    } ext_info_t;

    logic [`LQ_SIZE-1:0]  valid;
    logic [`LQ_SIZE-1:0]  miss;
    logic [`LQ_SIZE-1:0]  addr_valid;
    logic [`LQ_SIZE-1:0]  data_valid;
    logic [`LQ_SIZE-1:0]  written;
    logic [`LQ_SIZE-1:0]  pending;
    logic [`DATA_W-1:0]   data [`LQ_SIZE];
    ext_info_t            info [`LQ_SIZE];
    rob_idx_t             rob_tab [`LQ_SIZE];
    logic [`PREG_W-1:0]   rd_tab [`LQ_SIZE];
    logic [`LQ_IDX_W-1:0] wb_idx;
    logic [`LQ_IDX_W-1:0] fill_idx;
    ext_info_t            fill_info;
    logic [`DATA_W-1:0]   fill_merged;
    logic [`DATA_W-1:0]   fill_shifted;
    logic [`DATA_W-1:0]   fill_res;
    logic                 wb_fire;

    function automatic logic [`DATA_W-1:0] load_extend(logic uext, ld_size_e size,
                                                       logic [`DATA_W-1:0] w);
        logic [`DATA_W-1:0] r;
        case (size)
            LD_B:    r = {{(`DATA_W-8){~uext & w[7]}}, w[7:0]};
            LD_H:    r = {{(`DATA_W-16){~uext & w[15]}}, w[15:0]};
            LD_W:    r = {{(`DATA_W-32){~uext & w[31]}}, w[31:0]};
            default: r = w;
        endcase
        return r;
    endfunction

    // Refill path: forwarded bytes win over cache bytes
    assign fill_idx  = refill.lq_idx.idx;
    assign fill_info = info[fill_idx];

    always_comb begin
        for (int b = 0; b < `DATA_BYTES; b++) begin
            fill_merged[b*8 +: 8] = fill_info.rmask[b] ? data[fill_idx][b*8 +: 8]
                                                       : refill.data[b*8 +: 8];
        end
    end

    assign fill_shifted = fill_merged >> {fill_info.offset, 3'b000};
    assign fill_res     = load_extend(fill_info.uext, fill_info.size, fill_shifted);

    // Lowest missed entry with data still owed to the ROB
    assign pending = valid & miss & data_valid & ~written;

    always_comb begin
        wb_idx = '0;
        for (int i = `LQ_SIZE-1; i >= 0; i--) begin
            if (pending[i]) begin
                wb_idx = (`LQ_IDX_W)'(i);
            end
        end
    end

    assign wb.en      = |pending;
    assign wb.rob_idx = rob_tab[wb_idx];
    assign wb.rd      = rd_tab[wb_idx];
    assign wb.res     = data[wb_idx];
    assign wb_fire    = wb.en && wb_ready;

    assign addr_valid_vec = valid & addr_valid;
    assign rd_rob         = rob_tab[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            miss       <= '0;
            addr_valid <= '0;
            data_valid <= '0;
            written    <= '0;
        end else begin
            if (alloc) begin
                valid[alloc_idx.idx]      <= 1'b1;
                miss[alloc_idx.idx]       <= 1'b0;
                addr_valid[alloc_idx.idx] <= 1'b0;
                data_valid[alloc_idx.idx] <= 1'b0;
                written[alloc_idx.idx]    <= 1'b0;
            end
            if (ld.en) begin
                miss[ld.lq_idx.idx]       <= ld.miss;
                addr_valid[ld.lq_idx.idx] <= 1'b1;
                data_valid[ld.lq_idx.idx] <= ~ld.miss;
                written[ld.lq_idx.idx]    <= ~ld.miss;  // Hits go back through the pipeline
            end
            if (refill.en) begin
                data_valid[fill_idx] <= 1'b1;
            end
            if (wb_fire) begin
                written[wb_idx] <= 1'b1;
            end
            if (flush) begin
                valid <= valid & keep_mask;
            end
            for (int i = 0; i < `COMMIT_W; i++) begin
                if (i < commit_num) begin
                    valid[head.idx + (`LQ_IDX_W)'(i)] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld.en) begin
            data[ld.lq_idx.idx]      <= ld.rdata;
            info[ld.lq_idx.idx]      <= '{uext: ld.uext, size: ld.size,
                                          offset: ld.paddr[`OFFSET_W-1:0], rmask: ld.rmask};
            rob_tab[ld.lq_idx.idx]   <= ld.rob_idx;
            rd_tab[ld.lq_idx.idx]    <= ld.rd;
            word_addr[ld.lq_idx.idx] <= ld.paddr[`PADDR_W-1:`OFFSET_W];
            byte_mask[ld.lq_idx.idx] <= ld.mask;
        end
        if (refill.en) begin
            data[fill_idx] <= fill_res;
        end
    end

endmodule

// File: hdl/lq_pkg.sv
`include "lq_defines.svh"

package lq_pkg;

    typedef struct packed {
        logic                 dir;
        logic [`LQ_IDX_W-1:0] idx;
    } lq_idx_t;

    typedef struct packed {
        logic                  dir;
        logic [`ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        LD_B,
        LD_H,
        LD_W,
        LD_D
    } ld_size_e;

    typedef struct packed {
        logic     en;
        rob_idx_t rob_idx;
    } dis_req_t;

    // One load leaving the load pipeline
    typedef struct packed {
        logic                   en;
        logic                   miss;
        lq_idx_t                lq_idx;
        rob_idx_t               rob_idx;
        logic [`PREG_W-1:0]     rd;
        logic                   uext;
        ld_size_e               size;
        logic [`PADDR_W-1:0]    paddr;
        logic [`DATA_BYTES-1:0] mask;   // Bytes read
        logic [`DATA_BYTES-1:0] rmask;  // Bytes already forwarded
        logic [`DATA_W-1:0]     rdata;
    } ld_issue_t;

    typedef struct packed {
        logic               en;
        lq_idx_t            lq_idx;
        logic [`DATA_W-1:0] data;
    } refill_t;

    typedef struct packed {
        logic                   en;
        lq_idx_t                lq_idx;  // Tail seen by the store at dispatch
        logic [`PADDR_W-1:0]    paddr;
        logic [`DATA_BYTES-1:0] mask;
    } st_check_t;

    typedef struct packed {
        logic     en;
        lq_idx_t  lq_idx;
        rob_idx_t rob_idx;
    } violation_t;

    typedef struct packed {
        logic               en;
        rob_idx_t           rob_idx;
        logic [`PREG_W-1:0] rd;
        logic [`DATA_W-1:0] res;
    } wb_t;

    typedef struct packed {
        logic     en;
        rob_idx_t rob_idx;
    } redirect_t;

endpackage

// File: hdl/lq_violation.sv
`timescale 1ns/1ps
`include "lq_defines.svh"

module lq_violation (
    input  logic                                           clk,
    input  logic                                           rst,
    input  lq_pkg::st_check_t                              st,
    input  lq_pkg::lq_idx_t                                head,
    input  lq_pkg::lq_idx_t                                tail,
    input  logic [`LQ_SIZE-1:0]                            addr_valid_vec,
    input  logic [`LQ_SIZE-1:0][`PADDR_W-`OFFSET_W-1:0]   word_addr,
    input  logic [`LQ_SIZE-1:0][`DATA_BYTES-1:0]          byte_mask,
    input  lq_pkg::rob_idx_t                               rd_rob,
    output logic [`LQ_IDX_W-1:0]                           rd_idx,
    output lq_pkg::violation_t                             violation
);
    import lq_pkg::*;

    logic [`LQ_IDX_W:0]  occ;
    logic [`LQ_IDX_W:0]  st_off;
    logic [`LQ_SIZE-1:0] younger;
    logic [`LQ_SIZE-1:0] hit_vec;
    logic [`LQ_SIZE-1:0] hit_q;
    lq_idx_t             st_idx_q;
    lq_idx_t             oldest;
    logic                vio_en;
    lq_idx_t             vio_idx;
    rob_idx_t            vio_rob;

    // Distances from head decide age
    assign occ    = tail - head;
    assign st_off = st.lq_idx - head;

    always_comb begin
        logic [`LQ_IDX_W:0] off;
        for (int j = 0; j < `LQ_SIZE; j++) begin
            off        = {1'b0, (`LQ_IDX_W)'(j) - head.idx};
            younger[j] = (off < occ) && (off >= st_off);
            hit_vec[j] = st.en && addr_valid_vec[j] && younger[j]
                         && (word_addr[j] == st.paddr[`PADDR_W-1:`OFFSET_W])
                         && |(byte_mask[j] & st.mask);
        end
    end

    // Stage 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_q <= '0;
        end else begin
            hit_q <= hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        st_idx_q <= st.lq_idx;
    end

    // First marked entry at or after the store, with wrap
    always_comb begin
        oldest = st_idx_q;
        for (int k = `LQ_SIZE-1; k >= 0; k--) begin
            if (hit_q[st_idx_q.idx + (`LQ_IDX_W)'(k)]) begin
                oldest = st_idx_q + (`LQ_IDX_W+1)'(k);
            end
        end
    end

    assign rd_idx = oldest.idx;

    // Stage 2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vio_en <= 1'b0;
        end else begin
            vio_en <= |hit_q;
        end
    end

    always_ff @(posedge clk) begin
        vio_idx <= oldest;
        vio_rob <= rd_rob;
    end

    assign violation.en      = vio_en;
    assign violation.lq_idx  = vio_idx;
    assign violation.rob_idx = vio_rob;

endmodule

// File: src.f
+incdir+hdl
hdl/lq_pkg.sv
hdl/lq_alloc.sv
hdl/lq_entries.sv
hdl/lq_violation.sv
hdl/load_queue.sv
tests/lq_sva.sv
tests/tb_load_queue.sv

// File: tests/lq_sva.sv
`timescale 1ns/1ps

module lq_sva (
    input logic               clk,
    input logic               rst,
    input lq_pkg::dis_req_t   dis,
    input lq_pkg::st_check_t  st,
    input logic               lq_full,
    input logic               wb_ready,
    input lq_pkg::wb_t        wb,
    input lq_pkg::violation_t violation
);

    int fail_cnt = 0;  // Failed assertions so far

    // Stalled writeback keeps presenting the same entry
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb.en && !wb_ready) |=> (wb.en && $stable(wb)))
        else begin
            fail_cnt++;
            $error("wb changed while wb_ready was low");
        end

    a_vio_latency: assert property (@(posedge clk) disable iff (rst)
        violation.en |-> $past(st.en, 2))  // Two-stage check
        else begin
            fail_cnt++;
            $error("violation.en without a store check two cycles earlier");
        end

    a_no_dis_full: assert property (@(posedge clk) disable iff (rst)
        lq_full |-> !dis.en)
        else begin
            fail_cnt++;
            $error("dispatch while the load queue is full");
        end

endmodule

bind load_queue lq_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .dis       (dis),
    .st        (st),
    .lq_full   (lq_full),
    .wb_ready  (wb_ready),
    .wb        (wb),
    .violation (violation)
);

// File: tests/tb_load_queue.sv
`timescale 1ns/1ps
`include "lq_defines.svh"

module tb_load_queue;
    import lq_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RST_CYCLES    = 8;
    localparam int FILL_CYCLES   = 30;  // Cycle budget of each test
    localparam int REFILL_CYCLES = 50;
    localparam int STALL_CYCLES  = 20;
    localparam int STORE_CYCLES  = 20;
    localparam int REDIR_CYCLES  = 20;
    localparam int RUN_CYCLES    = RST_CYCLES + FILL_CYCLES + REFILL_CYCLES + STALL_CYCLES
                                   + STORE_CYCLES + REDIR_CYCLES;

    logic       clk;
    logic       rst;
    dis_req_t   dis;
    ld_issue_t  ld;
    refill_t    refill;
    st_check_t  st;
    redirect_t  redir;
    logic [1:0] commit_num;
    logic       wb_ready;
    lq_idx_t    dis_lq_idx;
    logic       lq_full;
    wb_t        wb;
    violation_t violation;

    integer     seed;
    bit         result_printed;

    load_queue i_dut (
        .clk        (clk),
        .rst        (rst),
        .dis        (dis),
        .ld         (ld),
        .refill     (refill),
        .st         (st),
        .redir      (redir),
        .commit_num (commit_num),
        .wb_ready   (wb_ready),
        .dis_lq_idx (dis_lq_idx),
        .lq_full    (lq_full),
        .wb         (wb),
        .violation  (violation)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_with_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        result_printed = 1'b1;
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, act, exp);
            result_printed = 1'b1;
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Bytes touched by an aligned load
    function automatic logic [7:0] bytes_read(ld_size_e size, logic [2:0] offset);
        logic [15:0] m;
        m = ((16'd1 << (1 << size)) - 16'd1) << offset;
        return m[7:0];
    endfunction

    // Forwarded bytes over the refill word, then shift to the offset and extend
    function automatic logic [63:0] expect_load(logic [63:0] fwd, logic [63:0] fill,
                                                logic [7:0] rmask, logic [2:0] offset,
                                                ld_size_e size, logic uext);
        logic [63:0] w;
        logic [63:0] keep;
        int          nbits;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = rmask[b] ? fwd[b*8 +: 8] : fill[b*8 +: 8];
        end
        w     = w >> (8 * offset);
        nbits = 8 << size;
        if (nbits == 64) begin
            return w;
        end
        keep = (64'd1 << nbits) - 64'd1;
        if (!uext && w[nbits-1]) begin
            return w | ~keep;
        end
        return w & keep;
    endfunction

    task automatic dispatch_one(input logic [5:0] rob, output lq_idx_t idx);
        idx         = dis_lq_idx;
        dis.en      = 1'b1;
        dis.rob_idx = {1'b0, rob};
        next_cycle();
        dis.en = 1'b0;
    endtask

    task automatic issue_load(input lq_idx_t idx, input logic [5:0] rob, input logic miss,
                              input ld_size_e size, input logic uext,
                              input logic [31:0] paddr, input logic [7:0] rmask,
                              input logic [63:0] rdata);
        ld         = '0;
        ld.en      = 1'b1;
        ld.miss    = miss;
        ld.lq_idx  = idx;
        ld.rob_idx = {1'b0, rob};
        ld.rd      = rob;  // Destination register follows the ROB slot
        ld.uext    = uext;
        ld.size    = size;
        ld.paddr   = paddr;
        ld.mask    = bytes_read(size, paddr[2:0]);
        ld.rmask   = rmask;
        ld.rdata   = rdata;
        next_cycle();
        ld.en = 1'b0;
    endtask

    task automatic refill_one(input lq_idx_t idx, input logic [63:0] data);
        refill.en     = 1'b1;
        refill.lq_idx = idx;
        refill.data   = data;
        next_cycle();
        refill.en = 1'b0;
    endtask

    task automatic set_store(input logic en, input lq_idx_t idx, input logic [31:0] paddr,
                             input logic [7:0] mask);
        st.en     = en;
        st.lq_idx = idx;
        st.paddr  = paddr;
        st.mask   = mask;
    endtask

    task automatic commit_loads(input int n);
        int left;
        left = n;
        while (left > 0) begin
            commit_num = (left >= 2) ? 2'd2 : 2'd1;
            left -= commit_num;
            next_cycle();
        end
        commit_num = 2'd0;
    endtask

    task automatic wait_wb(input int limit);
        int n;
        n = 0;
        while (!wb.en) begin
            if (n == limit) begin
                stop_with_error("wb.en did not rise after the refill");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic test_fill_wrap();
        lq_idx_t idx;
        for (int i = 0; i < `LQ_SIZE; i++) begin
            check_val("dis_lq_idx", dis_lq_idx, i);
            check_val("lq_full", lq_full, 1'b0);
            dispatch_one(6'(i), idx);
        end
        check_val("lq_full", lq_full, 1'b1);
        check_val("dis_lq_idx", dis_lq_idx, 5'h10);  // Wrapped, direction set
        commit_num = 2'd2;
        for (int k = 0; k < 8; k++) begin
            next_cycle();
            if (k == 0) begin
                check_val("lq_full", lq_full, 1'b0);
            end
        end
        commit_num = 2'd0;
        check_val("lq_full", lq_full, 1'b0);
        check_val("dis_lq_idx", dis_lq_idx, 5'h10);
    endtask

    task automatic test_hit_and_refill();
        lq_idx_t     idx;
        logic [5:0]  rob;
        logic [63:0] fwd;
        logic [63:0] fill;
        logic [7:0]  rmask;
        logic [2:0]  offset;
        logic [31:0] paddr;
        ld_size_e    size;
        dispatch_one(6'd20, idx);
        issue_load(idx, 6'd20, 1'b0, LD_D, 1'b0, 32'h0000_1000, 8'h00, 64'h1122_3344_5566_7788);
        repeat (3) begin
            check_val("wb.en", wb.en, 1'b0);
            next_cycle();
        end
        commit_loads(1);
        for (int s = 0; s < 4; s++) begin
            for (int u = 0; u < 2; u++) begin
                size   = ld_size_e'(s);
                rob    = 6'(21 + 2 * s + u);
                offset = 3'($random(seed) & (8 - (1 << s)));
                paddr  = $random(seed);
                paddr[2:0] = offset;
                fwd    = {$random(seed), $random(seed)};
                fill   = {$random(seed), $random(seed)};
                rmask  = 8'($random(seed)) & bytes_read(size, offset);
                if (u == 0) begin
                    fwd  = fwd | 64'h8080_8080_8080_8080;  // Negative field for sign fill
                    fill = fill | 64'h8080_8080_8080_8080;
                end
                dispatch_one(rob, idx);
                issue_load(idx, rob, 1'b1, size, 1'(u), paddr, rmask, fwd);
                check_val("wb.en", wb.en, 1'b0);
                refill_one(idx, fill);
                wait_wb(4);
                check_val("wb.rob_idx", wb.rob_idx, {1'b0, rob});
                check_val("wb.rd", wb.rd, rob);
                check_val("wb.res", wb.res, expect_load(fwd, fill, rmask, offset, size, 1'(u)));
                next_cycle();
                check_val("wb.en", wb.en, 1'b0);
                commit_loads(1);
            end
        end
    endtask

    task automatic test_backpressure();
        lq_idx_t     a;
        lq_idx_t     b;
        lq_idx_t     lo;
        lq_idx_t     hi;
        logic        a_first;
        logic [63:0] da;
        logic [63:0] db;
        logic [63:0] fa;
        logic [63:0] fb;
        logic [63:0] exp_lo;
        logic [63:0] exp_hi;
        logic [5:0]  rob_lo;
        logic [5:0]  rob_hi;
        wb_ready = 1'b0;
        da = {$random(seed), $random(seed)};
        db = {$random(seed), $random(seed)};
        fa = {$random(seed), $random(seed)};
        fb = {$random(seed), $random(seed)};
        dispatch_one(6'd30, a);
        dispatch_one(6'd31, b);
        issue_load(a, 6'd30, 1'b1, LD_D, 1'b0, 32'h0000_2000, 8'h0F, da);
        issue_load(b, 6'd31, 1'b1, LD_D, 1'b0, 32'h0000_2008, 8'h00, db);
        a_first = a.idx < b.idx;
        lo      = a_first ? a : b;
        hi      = a_first ? b : a;
        rob_lo  = a_first ? 6'd30 : 6'd31;
        rob_hi  = a_first ? 6'd31 : 6'd30;
        exp_lo  = a_first ? expect_load(da, fa, 8'h0F, 3'd0, LD_D, 1'b0)
                          : expect_load(db, fb, 8'h00, 3'd0, LD_D, 1'b0);
        exp_hi  = a_first ? expect_load(db, fb, 8'h00, 3'd0, LD_D, 1'b0)
                          : expect_load(da, fa, 8'h0F, 3'd0, LD_D, 1'b0);
        refill_one(lo, a_first ? fa : fb);
        wait_wb(4);
        refill_one(hi, a_first ? fb : fa);
        repeat (4) begin
            check_val("wb.en", wb.en, 1'b1);
            check_val("wb.rob_idx", wb.rob_idx, {1'b0, rob_lo});
            check_val("wb.res", wb.res, exp_lo);
            next_cycle();
        end
        wb_ready = 1'b1;
        next_cycle();
        check_val("wb.en", wb.en, 1'b1);
        check_val("wb.rob_idx", wb.rob_idx, {1'b0, rob_hi});
        check_val("wb.res", wb.res, exp_hi);
        next_cycle();
        check_val("wb.en", wb.en, 1'b0);
        commit_loads(2);
    endtask

    task automatic test_store_check();
        lq_idx_t l0;
        lq_idx_t l1;
        lq_idx_t l2;
        lq_idx_t st_mid;
        lq_idx_t st_late;
        dispatch_one(6'd40, l0);
        st_mid = dis_lq_idx;  // Store sits between l0 and l1
        dispatch_one(6'd41, l1);
        dispatch_one(6'd42, l2);
        st_late = dis_lq_idx;
        issue_load(l0, 6'd40, 1'b0, LD_D, 1'b1, 32'h0000_3000, 8'h00, 64'h0);
        issue_load(l1, 6'd41, 1'b0, LD_W, 1'b1, 32'h0000_3004, 8'h00, 64'h0);
        issue_load(l2, 6'd42, 1'b0, LD_H, 1'b1, 32'h0000_3006, 8'h00, 64'h0);
        // Three stores back to back; only the first hits younger loads
        set_store(1'b1, st_mid, 32'h0000_3006, 8'hC0);
        next_cycle();
        check_val("violation.en", violation.en, 1'b0);
        set_store(1'b1, st_mid, 32'h0000_3000, 8'h0F);
        next_cycle();
        check_val("violation.en", violation.en, 1'b1);
        check_val("violation.lq_idx", violation.lq_idx, l1);
        check_val("violation.rob_idx", violation.rob_idx, {1'b0, 6'd41});
        set_store(1'b1, st_late, 32'h0000_3000, 8'hFF);
        next_cycle();
        check_val("violation.en", violation.en, 1'b0);
        set_store(1'b0, st_late, 32'h0, 8'h00);
        next_cycle();
        check_val("violation.en", violation.en, 1'b0);
        commit_loads(3);
    endtask

    task automatic test_redirect();
        lq_idx_t ids [6];
        lq_idx_t old_tail;
        for (int i = 0; i < 6; i++) begin
            dispatch_one(6'(50 + i), ids[i]);
        end
        issue_load(ids[4], 6'd54, 1'b1, LD_D, 1'b0, 32'h0000_4000, 8'h00, 64'h0);
        old_tail      = dis_lq_idx;
        redir.en      = 1'b1;
        redir.rob_idx = {1'b0, 6'd52};
        next_cycle();
        redir.en = 1'b0;
        check_val("dis_lq_idx", dis_lq_idx, old_tail);
        next_cycle();
        check_val("dis_lq_idx", dis_lq_idx, ids[3]);  // First dropped load
        refill_one(ids[4], {$random(seed), $random(seed)});
        repeat (3) begin
            check_val("wb.en", wb.en, 1'b0);
            next_cycle();
        end
        commit_loads(3);
    endtask

    initial begin
        seed           = 32'hd031;
        result_printed = 1'b0;
        clk            = 1'b0;
        rst            = 1'b1;
        dis            = '0;
        ld             = '0;
        refill         = '0;
        st             = '0;
        redir          = '0;
        commit_num     = 2'd0;
        wb_ready       = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val("wb.en", wb.en, 1'b0);
        check_val("violation.en", violation.en, 1'b0);
        check_val("lq_full", lq_full, 1'b0);
        check_val("dis_lq_idx", dis_lq_idx, 5'h00);
        test_fill_wrap();
        test_hit_and_refill();
        test_backpressure();
        test_store_check();
        test_redirect();
        result_printed = 1'b1;
        if (i_dut.i_sva.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Error at %0t ns: %0d assertion failures", $time, i_dut.i_sva.fail_cnt);
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 2 * CLK_PERIOD);
        stop_with_error("watchdog expired before the tests finished");
    end

    final begin
        if (!result_printed) begin
            $display("Result: FAILED");
        end
    end

endmodule
